/* verification/booth_mul_testdata.txt */
// mx my product, hex, one vector per line
00 00 0000
ff ff fe01
01 ab 00ab
ab 01 00ab
ff 01 00ff
01 ff 00ff
00 ff 0000
ff 00 0000
80 80 4000
7f 7f 3f01
0f f0 0e10
f0 0f 0e10
55 aa 3872
aa 55 3872
03 07 0015
1c 33 0594
38 c9 2bf8
e3 5d 5277
24 fe 23b8
92 11 09b2
07 ff 06f9
fc 3c 3b10
6c 99 408c
c5 e7 b1c3
20 37 06e0

/* all.f */
verilog/booth_mul_pkg.sv
verilog/prefix_adder.sv
verilog/booth_recoder.sv
verilog/pp_row.sv
verilog/wallace_compressor.sv
verilog/product_buffer.sv
verilog/booth_mul_top.sv
verification/booth_mul_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := booth_mul_tb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/booth_mul_tb.sv */
`timescale 1ns/1ps

module booth_mul_tb;

   localparam int BUF_DEPTH    = 4;
   localparam int SINK_CREDITS = 2;
   localparam int N_VEC        = 25;
   localparam int CLK_PERIOD   = 8;
   localparam int RST_CYCLES   = 8;
   localparam int IDLE_CYCLES  = 4;
   localparam int WATCHDOG_NS  = (RST_CYCLES + IDLE_CYCLES + 60 * N_VEC) * CLK_PERIOD;

   logic                         CLK;
   logic                         rst;
   logic                         in_valid;
   booth_mul_pkg::mul_operands_t in_operands;
   logic                         in_credit;
   logic                         out_valid;
   booth_mul_pkg::product_t      out_product;
   logic                         out_credit;

   // Words mx, my and product for each vector
   logic [15:0] vec_mem [3*N_VEC];

   int          sent         = 0;
   int          returned     = 0;
   int          received     = 0;
   int          dut_credits  = SINK_CREDITS;
   logic        stim_started = 1'b0;
   logic [31:0] lfsr         = 32'h326f_af88;

   booth_mul_top #(
      .BUF_DEPTH   (BUF_DEPTH),
      .SINK_CREDITS(SINK_CREDITS)
   ) u_booth_mul_top (
      .CLK        (CLK),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_operands(in_operands),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_product(out_product),
      .out_credit (out_credit)
   );

   initial CLK = 1'b0;
   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic int producer_credits();
      return BUF_DEPTH - sent + returned;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_product(input int idx, input booth_mul_pkg::product_t actual);
      booth_mul_pkg::product_t expected;
      expected = vec_mem[3*idx+2];
      assert (actual === expected)
         else fail_run($sformatf("MISMATCH vec_%0d expected %04h actual %04h",
                                 idx, expected, actual));
   endtask

   task automatic produce();
      while (sent < N_VEC) begin
         @(posedge CLK);
         #1;
         if (producer_credits() > 0) begin
            in_valid       = 1'b1;
            in_operands.mx = vec_mem[3*sent][7:0];
            in_operands.my = vec_mem[3*sent+1][7:0];
            sent++;
         end else begin
            in_valid = 1'b0;
         end
      end
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
   endtask

   // Random grants capped at the sink's credit limit
   task automatic consume();
      logic grant;
      while (received < N_VEC) begin
         @(posedge CLK);
         #1;
         grant = lfsr[0];
         lfsr  = lfsr_next(lfsr);
         out_credit = grant && (dut_credits < SINK_CREDITS);
      end
      @(posedge CLK);
      #1;
      out_credit = 1'b0;
   endtask

   // DUT outputs are stable at the falling edge
   always @(negedge CLK) begin
      if (!rst) begin
         if (!stim_started) begin
            assert (!out_valid && !in_credit)
               else fail_run("out_valid or in_credit went high before any input was sent");
         end
         if (out_valid) begin
            assert (dut_credits > 0)
               else fail_run("credit violation, out_valid while the DUT held no output credit");
            assert (received < N_VEC)
               else fail_run("extra result after all vectors were received");
            check_product(received, out_product);
            received++;
         end
         if (in_credit) begin
            returned++;
         end
         assert (producer_credits() >= 0 && producer_credits() <= BUF_DEPTH)
            else fail_run("input credit count left the range 0 to BUF_DEPTH");
         dut_credits = dut_credits + int'(out_credit) - int'(out_valid);
      end
   end

   initial begin
      #(WATCHDOG_NS);
      fail_run("timeout before all results were received");
   end

   initial begin
      rst         = 1'b1;
      in_valid    = 1'b0;
      in_operands = '0;
      out_credit  = 1'b0;
      $readmemh("verification/booth_mul_testdata.txt", vec_mem);
      repeat (RST_CYCLES) @(posedge CLK);
      #1;
      rst = 1'b0;
      // Quiet window to watch the outputs idle
      repeat (IDLE_CYCLES) @(posedge CLK);
      stim_started = 1'b1;
      fork
         produce();
         consume();
      join
      repeat (2 * BUF_DEPTH) @(negedge CLK);
      assert (producer_credits() == BUF_DEPTH)
         else fail_run("input credits were not all returned after draining");
      $display("TEST OK");
      $finish;
   end

endmodule

/* verilog/booth_mul_top.sv */
`timescale 1ns/1ps

module booth_mul_top #(
   parameter int BUF_DEPTH    = 4,
   parameter int SINK_CREDITS = 2
) (
   input  logic                         CLK,
   input  logic                         rst,
   input  logic                         in_valid,
   input  booth_mul_pkg::mul_operands_t in_operands,
   output logic                         in_credit,
   output logic                         out_valid,
   output booth_mul_pkg::product_t      out_product,
   input  logic                         out_credit
);

   logic                        stage_valid;
   booth_mul_pkg::booth_digit_t digits [booth_mul_pkg::GROUP_CNT];
   booth_mul_pkg::operand_t     my;
   booth_mul_pkg::triple_t      my_triple;
   booth_mul_pkg::row_t         rows [booth_mul_pkg::GROUP_CNT];
   logic                        prod_valid;
   booth_mul_pkg::product_t     prod;

   booth_recoder u_booth_recoder (
      .CLK        (CLK),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_operands(in_operands),
      .stage_valid(stage_valid),
      .digits     (digits),
      .my         (my),
      .my_triple  (my_triple)
   );

   for (genvar g = 0; g < booth_mul_pkg::GROUP_CNT; g++) begin : gen_rows
      pp_row u_pp_row (
         .digit    (digits[g]),
         .my       (my),
         .my_triple(my_triple),
         .row      (rows[g])
      );
   end

   wallace_compressor u_wallace_compressor (
      .CLK        (CLK),
      .rst        (rst),
      .stage_valid(stage_valid),
      .rows       (rows),
      .digits     (digits),
      .prod_valid (prod_valid),
      .prod       (prod)
   );

   product_buffer #(
      .BUF_DEPTH   (BUF_DEPTH),
      .SINK_CREDITS(SINK_CREDITS)
   ) u_product_buffer (
      .CLK        (CLK),
      .rst        (rst),
      .prod_valid (prod_valid),
      .prod       (prod),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_product(out_product),
      .out_credit (out_credit)
   );

endmodule

/* verilog/product_buffer.sv */
`timescale 1ns/1ps

module product_buffer #(
   parameter int BUF_DEPTH    = 4,
   parameter int SINK_CREDITS = 2
) (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    prod_valid,
   input  booth_mul_pkg::product_t prod,
   output logic                    in_credit,
   output logic                    out_valid,
   output booth_mul_pkg::product_t out_product,
   input  logic                    out_credit
);

   localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CNT_W = $clog2(BUF_DEPTH + 1);
   localparam int CRD_W = $clog2(SINK_CREDITS + 1);

   booth_mul_pkg::product_t mem [BUF_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic [CRD_W-1:0] credits;
   logic             pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // Input credits bound the fill, so no full check on push
   assign pop         = (fill != '0) && (credits != '0);
   assign out_valid   = pop;
   assign in_credit   = pop;
   assign out_product = mem[rd_ptr];

   always_ff @(posedge CLK) begin
      if (prod_valid) begin
         mem[wr_ptr] <= prod;
      end
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (prod_valid) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({prod_valid, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // Credits granted by the consumer
   always_ff @(posedge CLK) begin
      if (rst) begin
         credits <= CRD_W'(SINK_CREDITS);
      end else begin
         case ({out_credit, pop})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

endmodule

/* verilog/wallace_compressor.sv */
`timescale 1ns/1ps

module wallace_compressor (
   input  logic                        CLK,
   input  logic                        rst,
   input  logic                        stage_valid,
   input  booth_mul_pkg::row_t         rows [booth_mul_pkg::GROUP_CNT],
   input  booth_mul_pkg::booth_digit_t digits [booth_mul_pkg::GROUP_CNT],
   output logic                        prod_valid,
   output booth_mul_pkg::product_t     prod
);

   localparam int P_W     = $bits(booth_mul_pkg::product_t);
   localparam int FINAL_W = P_W - 2;

   // Rows aligned to product bit positions
   booth_mul_pkg::product_t pp0;
   booth_mul_pkg::product_t pp1;
   booth_mul_pkg::product_t pp2;
   booth_mul_pkg::product_t cv;

   booth_mul_pkg::product_t s1_sum;
   booth_mul_pkg::product_t c1;
   booth_mul_pkg::product_t s1_carry;
   booth_mul_pkg::product_t s1_rest;

   booth_mul_pkg::product_t s2_sum;
   booth_mul_pkg::product_t c2;

   logic [FINAL_W-1:0] final_hi;

   function automatic logic [1:0] half_add(input logic a, input logic b);
      return {a & b, a ^ b};
   endfunction

   function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
      logic t;
      t = a ^ b;
      return {(a & b) | (t & c), t ^ c};
   endfunction

   assign pp0 = {5'b0, ~digits[0].neg, rows[0]};
   assign pp1 = {2'b0, ~digits[1].neg, rows[1], 3'b0};
   assign pp2 = {rows[2], 6'b0};
   assign cv  = booth_mul_pkg::CORRECTION_BASE | {12'b0, digits[1].neg, 2'b0, digits[0].neg};

   // First level, four inputs per column at most
   always_comb begin
      logic [1:0] res;
      for (int j = 0; j < P_W; j++) begin
         if (j < 3) begin
            res = half_add(pp0[j], cv[j]);
         end else if (j < 11) begin
            res = full_add(cv[j], pp0[j], pp1[j]);
         end else if (j < 14) begin
            res = full_add(cv[j], pp1[j], pp2[j]);
         end else begin
            res = half_add(cv[j], pp2[j]);
         end
         s1_sum[j] = res[0];
         c1[j]     = res[1];
      end
   end

   // Carries move up one column, bit 15 carry falls off the product
   assign s1_carry = {c1[P_W-2:0], 1'b0};

   // Low bits of row 2 skip the first level
   assign s1_rest = {5'b0, pp2[10:6], 6'b0};

   // Second level down to sum and carry vectors
   always_comb begin
      logic [1:0] res;
      for (int j = 0; j < P_W; j++) begin
         if (j >= 6 && j <= 10) begin
            res = full_add(s1_sum[j], s1_carry[j], s1_rest[j]);
         end else begin
            res = half_add(s1_sum[j], s1_carry[j]);
         end
         s2_sum[j] = res[0];
         c2[j]     = res[1];
      end
   end

   // Bits 1..0 are already final, c2[0] is always zero
   prefix_adder #(
      .ADD_W(FINAL_W)
   ) u_final_adder (
      .a   (s2_sum[P_W-1:2]),
      .b   (c2[P_W-2:1]),
      .sum (final_hi),
      .cout()
   );

   always_ff @(posedge CLK) begin
      if (rst) begin
         prod_valid <= 1'b0;
      end else begin
         prod_valid <= stage_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (stage_valid) begin
         prod <= {final_hi, s2_sum[1:0]};
      end
   end

endmodule

/* verilog/pp_row.sv */
`timescale 1ns/1ps

module pp_row (
   input  booth_mul_pkg::booth_digit_t digit,
   input  booth_mul_pkg::operand_t     my,
   input  booth_mul_pkg::triple_t      my_triple,
   output booth_mul_pkg::row_t         row
);

   booth_mul_pkg::row_t my_x1;
   booth_mul_pkg::row_t my_x2;
   booth_mul_pkg::row_t my_x4;
   booth_mul_pkg::row_t magnitude;

   assign my_x1 = {2'b00, my};
   assign my_x2 = {1'b0, my, 1'b0};
   assign my_x4 = {my, 2'b00};

   // At most one select is set, zero digit gives zero
   assign magnitude = ({booth_mul_pkg::ROW_W{digit.single}} & my_x1)
                    | ({booth_mul_pkg::ROW_W{digit.double}} & my_x2)
                    | ({booth_mul_pkg::ROW_W{digit.triple}} & my_triple)
                    | ({booth_mul_pkg::ROW_W{digit.quad}}   & my_x4);

   // One's complement for negative digits
   // The missing +1 is added through the correction vector
   assign row = magnitude ^ {booth_mul_pkg::ROW_W{digit.neg}};

endmodule

/* verilog/booth_recoder.sv */
`timescale 1ns/1ps

module booth_recoder (
   input  logic                         CLK,
   input  logic                         rst,
   input  logic                         in_valid,
   input  booth_mul_pkg::mul_operands_t in_operands,
   output logic                         stage_valid,
   output booth_mul_pkg::booth_digit_t  digits [booth_mul_pkg::GROUP_CNT],
   output booth_mul_pkg::operand_t      my,
   output booth_mul_pkg::triple_t       my_triple
);

   booth_mul_pkg::mul_operands_t ops_r;
   booth_mul_pkg::operand_t      triple_hi;
   logic                         triple_cout;
   logic [3:0]                   window [booth_mul_pkg::GROUP_CNT];

   function automatic booth_mul_pkg::booth_digit_t encode_digit(input logic [3:0] x);
      booth_mul_pkg::booth_digit_t d;
      logic w0;
      logic w1;
      logic w2;
      w0 = x[0] ^ x[1];
      w1 = x[1] ^ x[2];
      w2 = x[2] ^ x[3];
      d.single = w0 & ~w2;
      d.double = w1 & ~w0;
      d.triple = w2 & w0;
      d.quad   = w2 & ~(w0 | w1);
      d.neg    = x[3];
      return d;
   endfunction

   always_ff @(posedge CLK) begin
      if (rst) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= in_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (in_valid) begin
         ops_r <= in_operands;
      end
   end

   // Overlapping windows of mx
   // Zero on top of the last window keeps mx unsigned
   assign window[0] = {ops_r.mx[2:0], 1'b0};
   assign window[1] = ops_r.mx[5:2];
   assign window[2] = {1'b0, ops_r.mx[7:5]};

   for (genvar g = 0; g < booth_mul_pkg::GROUP_CNT; g++) begin : gen_digit
      assign digits[g] = encode_digit(window[g]);
   end

   // 3*my as 2*my + my, bit 0 of 2*my is zero
   prefix_adder #(
      .ADD_W(booth_mul_pkg::OPERAND_W)
   ) u_triple_adder (
      .a   (ops_r.my),
      .b   ({1'b0, ops_r.my[booth_mul_pkg::OPERAND_W-1:1]}),
      .sum (triple_hi),
      .cout(triple_cout)
   );

   assign my        = ops_r.my;
   assign my_triple = {triple_cout, triple_hi, ops_r.my[0]};

endmodule

/* verilog/prefix_adder.sv */
`timescale 1ns/1ps

module prefix_adder #(
   parameter int ADD_W = 8
) (
   input  logic [ADD_W-1:0] a,
   input  logic [ADD_W-1:0] b,
   output logic [ADD_W-1:0] sum,
   output logic             cout
);

   localparam int LEVELS = $clog2(ADD_W);

   // Group generate and propagate after each prefix level
   logic [ADD_W-1:0] grp_g [LEVELS+1];
   logic [ADD_W-1:0] grp_p [LEVELS+1];
   logic [ADD_W:0]   carry;

   assign grp_g[0] = a & b;
   assign grp_p[0] = a ^ b;

   for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : gen_level
      localparam int SPAN = 1 << lvl;

      for (genvar i = 0; i < ADD_W; i++) begin : gen_bit
         if (i >= SPAN) begin : gen_cell
            assign grp_g[lvl+1][i] = grp_g[lvl][i] | (grp_p[lvl][i] & grp_g[lvl][i-SPAN]);
            assign grp_p[lvl+1][i] = grp_p[lvl][i] & grp_p[lvl][i-SPAN];
         end else begin : gen_pass
            // Already complete down to bit 0
            assign grp_g[lvl+1][i] = grp_g[lvl][i];
            assign grp_p[lvl+1][i] = grp_p[lvl][i];
         end
      end
   end

   // Carry into bit i is the group generate of bits i-1 down to 0
   assign carry = {grp_g[LEVELS], 1'b0};

   assign sum  = grp_p[0] ^ carry[ADD_W-1:0];
   assign cout = carry[ADD_W];

endmodule

/* verilog/booth_mul_pkg.sv */
package booth_mul_pkg;

   localparam int OPERAND_W = 8;

   // Radix-8 digits needed to cover an unsigned 8-bit multiplier
   localparam int GROUP_CNT = 3;

   // Largest magnitude is 4*my, which needs two bits above the operand
   localparam int ROW_W = OPERAND_W + 2;

   typedef logic [OPERAND_W-1:0]   operand_t;
   typedef logic [OPERAND_W+1:0]   triple_t;
   typedef logic [2*OPERAND_W-1:0] product_t;
   typedef logic [ROW_W-1:0]       row_t;

   // One-hot magnitude select plus sign of a Booth digit
   typedef struct packed {
      logic single;
      logic double;
      logic triple;
      logic quad;
      logic neg;
   } booth_digit_t;

   typedef struct packed {
      operand_t mx;
      operand_t my;
   } mul_operands_t;

   // Sign extension constant of the three rows
   // Neg flags of digits 0 and 1 are ORed in at bits 0 and 3
   localparam product_t CORRECTION_BASE = 16'b1101_1100_0000_0000;

endpackage
